//--- all.f
rtl/issue_pkg.sv
rtl/slot_select.sv
rtl/latency_timer.sv
rtl/reservation_station.sv
rtl/issue_select.sv
rtl/exec_lanes.sv
rtl/flush_control.sv
rtl/issue_cluster.sv
verification/issue_cluster_tb.sv

//--- Makefile
# Verilator build and run of the issue cluster testbench

VERILATOR  ?= verilator
TOP        ?= issue_cluster_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= *** PASSED ***

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard rtl/*.sv verification/*.sv)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/issue_cluster_tb.sv
// Directed testbench of the issue cluster; drives dispatch and mispredict, checks every CDB result
module issue_cluster_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period   = 100;
    localparam int drive_delay  = 1;                          // After the rising edge
    localparam int reset_cycles = 5;
    localparam int wait_limit   = 24;                         // Per result
    localparam int test_cycles  = 4 + 8 + 14 + 14 + 22 + 24;  // Reset, indep, chain, mul, fill, flush
    localparam int tag_count    = 2 ** issue_pkg::tag_width;

    logic                                        clock, reset, mispredict;
    logic [issue_pkg::n_way-1:0]                 alloc_valid;
    issue_pkg::rs_entry_t [issue_pkg::n_way-1:0] alloc_entries;
    issue_pkg::cdb_packet_t                      cdb;
    issue_pkg::free_count_t                      free_count;
    logic                                        dispatch_ready;

    // Reference model, indexed by destination tag
    issue_pkg::rs_entry_t model [tag_count];
    issue_pkg::data_t     exp_value [tag_count];
    bit                   issued [tag_count], squashed [tag_count], seen [tag_count];
    int                   drive_cycle [tag_count], seen_cycle [tag_count];
    int                   cycle = 0, errors = 0, results = 0, next_tag = 1;

    issue_cluster i_dut (.clock, .reset, .alloc_valid, .alloc_entries, .mispredict,
                         .cdb, .free_count, .dispatch_ready);

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;  // Settled by drive time

    initial begin  // Hang guard, twice the expected run
        #(2 * clk_period * (reset_cycles + test_cycles));
        $display("Watchdog expired, the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // Model and reporting
    //////////////////////////////////////////////////

    function automatic issue_pkg::data_t op_result(input issue_pkg::alu_op_t op,
                                                   input issue_pkg::data_t a,
                                                   input issue_pkg::data_t b);
        logic [2*issue_pkg::data_width-1:0] product;
        product = a * b;
        case (op)
            issue_pkg::alu_add: return a + b;
            issue_pkg::alu_sub: return a - b;
            issue_pkg::alu_xor: return a ^ b;
            default:            return product[issue_pkg::data_width-1:0];  // Low half
        endcase
    endfunction

    function automatic issue_pkg::tag_t new_tag();  // Unique over the whole run
        next_tag++;
        return issue_pkg::tag_t'(next_tag - 1);
    endfunction

    // A source not ready waits on its tag, a ready one gets a random value
    function automatic issue_pkg::rs_entry_t make_entry(input issue_pkg::alu_op_t op,
            input issue_pkg::tag_t dest, input logic r1, input issue_pkg::tag_t t1,
            input logic r2, input issue_pkg::tag_t t2);
        issue_pkg::rs_entry_t e;
        e            = '0;
        e.valid      = 1'b1;
        e.op         = op;
        e.dest_tag   = dest;
        e.src1_ready = r1;
        e.src1_tag   = r1 ? '0 : t1;
        e.src1_value = r1 ? issue_pkg::data_t'($urandom) : '0;
        e.src2_ready = r2;
        e.src2_tag   = r2 ? '0 : t2;
        e.src2_value = r2 ? issue_pkg::data_t'($urandom) : '0;
        return e;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int got);
        errors++;
        $display("ERR %0t %s: expected %0d, got %0d", $time, name, expected, got);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    // One CDB slot; expected value built from producers already seen
    task automatic record_result(input int slot, input issue_pkg::tag_t tag,
                                 input issue_pkg::data_t value);
        issue_pkg::rs_entry_t e;
        issue_pkg::data_t     a, b;
        e = model[tag];
        if (!issued[tag] || squashed[tag] || seen[tag]) begin
            report_failure($sformatf("tag %0d on cdb slot %0d not expected (squashed %0d, seen %0d)",
                                     tag, slot, squashed[tag], seen[tag]));
            return;
        end
        results++;
        seen[tag]       = 1'b1;
        seen_cycle[tag] = cycle;
        if (slot != ((e.op == issue_pkg::alu_mul) ? 1 : 0))
            report_failure($sformatf("tag %0d came out on the wrong cdb slot %0d", tag, slot));
        if ((!e.src1_ready && !seen[e.src1_tag]) || (!e.src2_ready && !seen[e.src2_tag]))
            report_failure($sformatf("tag %0d broadcast before its producer", tag));
        a              = e.src1_ready ? e.src1_value : exp_value[e.src1_tag];
        b              = e.src2_ready ? e.src2_value : exp_value[e.src2_tag];
        exp_value[tag] = op_result(e.op, a, b);
        if (value != exp_value[tag])
            report_mismatch($sformatf("cdb.values[%0d] tag %0d", slot, tag),
                            int'(exp_value[tag]), int'(value));
    endtask

    always @(negedge clock) begin  // Mid-cycle, outputs stable
        if (!reset) begin
            for (int s = 0; s < issue_pkg::cdb_size; s++) begin
                if (cdb.valid[s]) record_result(s, cdb.tags[s], cdb.values[s]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        #drive_delay;
    endtask

    // Waits for room, then drives one cycle of allocation
    task automatic dispatch(input issue_pkg::rs_entry_t e0, input logic v0,
                            input issue_pkg::rs_entry_t e1, input logic v1);
        int n;
        n = 0;
        while ((!dispatch_ready || int'(free_count) < int'(v0) + int'(v1)) && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (n == wait_limit) begin
            report_failure("dispatch never had room for the next entries");
        end else begin
            alloc_valid      = {v1, v0};
            alloc_entries[0] = e0;
            alloc_entries[1] = e1;
            for (int l = 0; l < issue_pkg::n_way; l++) begin
                if (alloc_valid[l]) begin
                    model[alloc_entries[l].dest_tag]       = alloc_entries[l];
                    issued[alloc_entries[l].dest_tag]      = 1'b1;
                    drive_cycle[alloc_entries[l].dest_tag] = cycle;
                end
            end
            next_cycle();
            alloc_valid = '0;
        end
    endtask

    task automatic wait_result(input issue_pkg::tag_t tag);
        int n;
        n = 0;
        while (!seen[tag] && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (!seen[tag]) report_failure($sformatf("tag %0d never appeared on the cdb", tag));
    endtask

    task automatic check_arrival(input issue_pkg::tag_t tag, input int expected);
        if (seen_cycle[tag] != expected)
            report_mismatch($sformatf("arrival cycle of tag %0d", tag), expected, seen_cycle[tag]);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        @(negedge clock);
        if (cdb.valid != '0) report_mismatch("cdb.valid", 0, int'(cdb.valid));
        if (!dispatch_ready) report_mismatch("dispatch_ready", 1, 0);
        if (int'(free_count) != issue_pkg::n_way)
            report_mismatch("free_count", issue_pkg::n_way, int'(free_count));
        next_cycle();
    endtask

    task automatic test_independent();
        issue_pkg::tag_t ta, tb;
        ta = new_tag();
        tb = new_tag();
        dispatch(make_entry(issue_pkg::alu_add, ta, 1'b1, '0, 1'b1, '0), 1'b1,
                 make_entry(issue_pkg::alu_xor, tb, 1'b1, '0, 1'b1, '0), 1'b1);
        wait_result(ta);
        wait_result(tb);
        check_arrival(ta, drive_cycle[ta] + 2);
        check_arrival(tb, drive_cycle[tb] + 3);  // One ALU issue per cycle
    endtask

    task automatic test_chain();
        issue_pkg::tag_t t [4];
        for (int i = 0; i < 4; i++) t[i] = new_tag();
        dispatch(make_entry(issue_pkg::alu_add, t[0], 1'b1, '0, 1'b1, '0), 1'b1,
                 make_entry(issue_pkg::alu_sub, t[1], 1'b0, t[0], 1'b1, '0), 1'b1);
        dispatch(make_entry(issue_pkg::alu_xor, t[2], 1'b1, '0, 1'b0, t[1]), 1'b1,
                 make_entry(issue_pkg::alu_add, t[3], 1'b0, t[2], 1'b0, t[2]), 1'b1);
        for (int i = 0; i < 4; i++) wait_result(t[i]);
        for (int i = 1; i < 4; i++) check_arrival(t[i], seen_cycle[t[i-1]] + 2);  // Wakeup pace
    endtask

    task automatic test_multiply();
        issue_pkg::tag_t m1, m2, a1, a2;
        m1 = new_tag();
        m2 = new_tag();
        a1 = new_tag();
        a2 = new_tag();
        dispatch(make_entry(issue_pkg::alu_mul, m1, 1'b1, '0, 1'b1, '0), 1'b1,
                 make_entry(issue_pkg::alu_mul, m2, 1'b1, '0, 1'b1, '0), 1'b1);
        dispatch(make_entry(issue_pkg::alu_sub, a1, 1'b1, '0, 1'b1, '0), 1'b1,
                 make_entry(issue_pkg::alu_add, a2, 1'b1, '0, 1'b1, '0), 1'b1);
        wait_result(m1);
        wait_result(m2);
        wait_result(a1);
        wait_result(a2);
        check_arrival(m1, drive_cycle[m1] + 1 + issue_pkg::mul_latency);
        check_arrival(m2, seen_cycle[m1] + issue_pkg::mul_latency + 1);  // Held by busy time
        check_arrival(a1, drive_cycle[a1] + 2);
        if (seen_cycle[a2] >= seen_cycle[m2])
            report_failure("ALU work stalled behind the second multiply");
    endtask

    // Consumers fill the station, the ready producer goes in last
    task automatic test_fill();
        issue_pkg::tag_t      tp;
        issue_pkg::tag_t      tc [issue_pkg::rs_size-1];
        issue_pkg::rs_entry_t c [issue_pkg::rs_size-1];
        tp = new_tag();
        for (int i = 0; i < issue_pkg::rs_size - 1; i++) begin
            tc[i] = new_tag();
            c[i]  = make_entry(issue_pkg::alu_op_t'(i % 3), tc[i], 1'b0, tp, 1'b1, '0);
        end
        for (int i = 0; i < issue_pkg::rs_size - 2; i += 2) dispatch(c[i], 1'b1, c[i+1], 1'b1);
        dispatch(c[issue_pkg::rs_size-2], 1'b1,
                 make_entry(issue_pkg::alu_add, tp, 1'b1, '0, 1'b1, '0), 1'b1);
        if (free_count != '0) report_mismatch("free_count", 0, int'(free_count));
        wait_result(tp);
        for (int i = 0; i < issue_pkg::rs_size - 1; i++) wait_result(tc[i]);
        if (int'(free_count) != issue_pkg::n_way)
            report_mismatch("free_count", issue_pkg::n_way, int'(free_count));
    endtask

    // Waiters on a dead tag fill the station around a multiply, then a mispredict hits
    task automatic test_mispredict();
        issue_pkg::tag_t tz, tm, tn;
        issue_pkg::tag_t tw [issue_pkg::rs_size-1];
        int              n;
        tz = new_tag();  // Never produced
        tm = new_tag();
        tn = new_tag();
        for (int i = 0; i < issue_pkg::rs_size - 1; i++) tw[i] = new_tag();
        for (int i = 0; i < issue_pkg::rs_size - 2; i += 2) begin
            dispatch(make_entry(issue_pkg::alu_add, tw[i], 1'b0, tz, 1'b1, '0), 1'b1,
                     make_entry(issue_pkg::alu_xor, tw[i+1], 1'b1, '0, 1'b0, tz), 1'b1);
        end
        dispatch(make_entry(issue_pkg::alu_mul, tm, 1'b1, '0, 1'b1, '0), 1'b1,
                 make_entry(issue_pkg::alu_sub, tw[issue_pkg::rs_size-2], 1'b0, tz, 1'b0, tz),
                 1'b1);
        next_cycle();  // Multiply issued, timer running
        mispredict = 1'b1;  // Multiply now in flight
        squashed[tm] = 1'b1;
        for (int i = 0; i < issue_pkg::rs_size - 1; i++) squashed[tw[i]] = 1'b1;
        @(negedge clock);
        if (dispatch_ready) report_mismatch("dispatch_ready", 0, 1);
        @(posedge clock);
        #drive_delay mispredict = 1'b0;
        n = 0;
        while (!dispatch_ready && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (!dispatch_ready) report_failure("dispatch_ready never came back after the mispredict");
        if (int'(free_count) != issue_pkg::n_way)
            report_mismatch("free_count", issue_pkg::n_way, int'(free_count));
        dispatch(make_entry(issue_pkg::alu_sub, tn, 1'b1, '0, 1'b1, '0), 1'b1, '0, 1'b0);
        wait_result(tn);
        repeat (issue_pkg::mul_latency + 2) next_cycle();  // Late squashed results would show here
    endtask

    initial begin
        void'($urandom(32'hee5d_2c67));
        reset         = 1'b1;
        mispredict    = 1'b0;
        alloc_valid   = '0;
        alloc_entries = '0;
        repeat (reset_cycles) @(posedge clock);
        #drive_delay reset = 1'b0;
        test_reset_state();
        test_independent();
        test_chain();
        test_multiply();
        test_fill();
        test_mispredict();
        for (int t = 0; t < tag_count; t++) begin
            if (issued[t] && !squashed[t] && !seen[t])
                report_failure($sformatf("tag %0d was dispatched but never broadcast", t));
        end
        $display("Run complete: %0d results checked, %0d errors", results, errors);
        if (errors == 0) $display("*** PASSED ***");
        else             $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- rtl/issue_cluster.sv
// Top of the out-of-order issue cluster: station, selector, lanes and flush control around a two-slot CDB
module issue_cluster (
    input  logic                                        clock,
    input  logic                                        reset,

    // Dispatch
    input  logic [issue_pkg::n_way-1:0]                 alloc_valid,
    input  issue_pkg::rs_entry_t [issue_pkg::n_way-1:0] alloc_entries,
    input  logic                                        mispredict,

    output issue_pkg::cdb_packet_t                      cdb,
    output issue_pkg::free_count_t                      free_count,
    output logic                                        dispatch_ready
);

    issue_pkg::rs_entry_t [issue_pkg::rs_size-1:0] entries;
    logic [issue_pkg::n_way-1:0]                   clear_valid;
    issue_pkg::rs_idx_t [issue_pkg::n_way-1:0]     clear_idxs;
    issue_pkg::issue_packet_t                      alu_issue, mul_issue;
    logic                                          mul_busy;
    logic                                          flush, squash;

    reservation_station i_station (
        .clock         (clock),
        .reset         (reset),
        .alloc_valid   (alloc_valid),
        .alloc_entries (alloc_entries),
        .cdb           (cdb),           // Wakeup loop
        .clear_valid   (clear_valid),
        .clear_idxs    (clear_idxs),
        .flush         (flush),
        .entries       (entries),
        .free_count    (free_count)
    );

    issue_select i_select (
        .entries     (entries),
        .mul_busy    (mul_busy),
        .clear_valid (clear_valid),
        .clear_idxs  (clear_idxs),
        .alu_issue   (alu_issue),
        .mul_issue   (mul_issue)
    );

    exec_lanes i_lanes (
        .clock     (clock),
        .reset     (reset),
        .alu_issue (alu_issue),
        .mul_issue (mul_issue),
        .squash    (squash),
        .cdb       (cdb),
        .mul_busy  (mul_busy)
    );

    flush_control i_flush (
        .clock          (clock),
        .reset          (reset),
        .mispredict     (mispredict),
        .mul_busy       (mul_busy),
        .flush          (flush),
        .squash         (squash),
        .dispatch_ready (dispatch_ready)
    );

endmodule

//--- rtl/flush_control.sv
// Mispredict recovery FSM: flushes the station, squashes lanes and holds dispatch until the multiplier idles
module flush_control (
    input  logic clock,
    input  logic reset,
    input  logic mispredict,  // One-cycle pulse
    input  logic mul_busy,
    output logic flush,
    output logic squash,
    output logic dispatch_ready
);

    typedef enum logic [1:0] {
        st_run   = 2'd0,
        st_flush = 2'd1,
        st_drain = 2'd2
    } state_t;

    state_t state, cur_state, next_state;

    // A mispredict in run is the flush cycle itself
    assign cur_state = (state == st_run && mispredict) ? st_flush : state;

    always_comb begin
        case (cur_state)
            st_flush: next_state = mul_busy ? st_drain : st_run;
            st_drain: next_state = mul_busy ? st_drain : st_run;  // Wait out the multiplier
            default:  next_state = st_run;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) state <= st_run;
        else       state <= next_state;
    end

    assign flush          = (cur_state == st_flush);
    assign squash         = (cur_state != st_run);   // Flush and drain
    assign dispatch_ready = (cur_state == st_run);

endmodule

//--- rtl/exec_lanes.sv
// Execution lanes: single-cycle ALU on CDB slot 0 and unpipelined multiplier on CDB slot 1
module exec_lanes (
    input  logic                     clock,
    input  logic                     reset,
    input  issue_pkg::issue_packet_t alu_issue,
    input  issue_pkg::issue_packet_t mul_issue,
    input  logic                     squash,    // Kill in-flight work
    output issue_pkg::cdb_packet_t   cdb,
    output logic                     mul_busy
);

    //////////////////////////////////////////////////
    // ALU lane
    //////////////////////////////////////////////////

    issue_pkg::data_t alu_result;
    logic             alu_valid;
    issue_pkg::tag_t  alu_tag;
    issue_pkg::data_t alu_value;

    always_comb begin
        case (alu_issue.op)
            issue_pkg::alu_add: alu_result = alu_issue.src1_value + alu_issue.src2_value;
            issue_pkg::alu_sub: alu_result = alu_issue.src1_value - alu_issue.src2_value;
            default:            alu_result = alu_issue.src1_value ^ alu_issue.src2_value;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) alu_valid <= 1'b0;
        else       alu_valid <= alu_issue.valid && !squash;  // Squashed issue never broadcasts
        alu_tag   <= alu_issue.dest_tag;
        alu_value <= alu_result;
    end

    //////////////////////////////////////////////////
    // Multiply lane
    //////////////////////////////////////////////////

    logic             mul_start, mul_done;
    issue_pkg::tag_t  mul_tag;
    issue_pkg::data_t mul_value;

    assign mul_start = mul_issue.valid && !squash;

    always_ff @(posedge clock) begin
        if (mul_start) begin
            mul_tag   <= mul_issue.dest_tag;
            mul_value <= mul_issue.src1_value * mul_issue.src2_value;  // Low half of product
        end
    end

    latency_timer i_mul_timer (
        .clock  (clock),
        .reset  (reset),
        .start  (mul_start),
        .cancel (squash),
        .busy   (mul_busy),
        .done   (mul_done)
    );

    // Each lane owns its slot
    assign cdb.valid  = {mul_done, alu_valid};
    assign cdb.tags   = {mul_tag, alu_tag};
    assign cdb.values = {mul_value, alu_value};

endmodule

//--- rtl/issue_select.sv
// Issue selection: oldest-index ready entry per lane class, turned into issue packets and station clears
module issue_select (
    input  issue_pkg::rs_entry_t [issue_pkg::rs_size-1:0] entries,
    input  logic                                          mul_busy,  // Multiplier occupied

    output logic [issue_pkg::n_way-1:0]                   clear_valid,
    output issue_pkg::rs_idx_t [issue_pkg::n_way-1:0]     clear_idxs,
    output issue_pkg::issue_packet_t                      alu_issue,
    output issue_pkg::issue_packet_t                      mul_issue
);

    logic [issue_pkg::rs_size-1:0]      alu_req, mul_req;
    logic [0:0][issue_pkg::rs_size-1:0] alu_gnt, mul_gnt;
    issue_pkg::rs_idx_t                 alu_idx, mul_idx;

    // One-hot grant to entry index
    function automatic issue_pkg::rs_idx_t onehot_idx(input logic [issue_pkg::rs_size-1:0] onehot);
        issue_pkg::rs_idx_t idx;
        idx = '0;
        for (int i = 0; i < issue_pkg::rs_size; i++) begin
            if (onehot[i]) idx = issue_pkg::rs_idx_t'(i);
        end
        return idx;
    endfunction

    // Ready masks, both sources present
    always_comb begin
        for (int i = 0; i < issue_pkg::rs_size; i++) begin
            alu_req[i] = entries[i].valid && entries[i].src1_ready && entries[i].src2_ready
                      && entries[i].op != issue_pkg::alu_mul;
            mul_req[i] = entries[i].valid && entries[i].src1_ready && entries[i].src2_ready
                      && entries[i].op == issue_pkg::alu_mul && !mul_busy;  // Waits out busy time
        end
    end

    slot_select #(.width(issue_pkg::rs_size), .grants(1)) i_alu_select (
        .req (alu_req), .gnt_bus (alu_gnt)
    );

    slot_select #(.width(issue_pkg::rs_size), .grants(1)) i_mul_select (
        .req (mul_req), .gnt_bus (mul_gnt)
    );

    assign alu_idx = onehot_idx(alu_gnt[0]);
    assign mul_idx = onehot_idx(mul_gnt[0]);

    // Packets; payload follows the picked entry
    assign alu_issue = '{valid: |alu_gnt[0], op: entries[alu_idx].op,
                         dest_tag: entries[alu_idx].dest_tag,
                         src1_value: entries[alu_idx].src1_value,
                         src2_value: entries[alu_idx].src2_value};
    assign mul_issue = '{valid: |mul_gnt[0], op: entries[mul_idx].op,
                         dest_tag: entries[mul_idx].dest_tag,
                         src1_value: entries[mul_idx].src1_value,
                         src2_value: entries[mul_idx].src2_value};

    assign clear_valid = {mul_issue.valid, alu_issue.valid};  // Lane 0 ALU, lane 1 MUL
    assign clear_idxs  = {mul_idx, alu_idx};

endmodule

//--- rtl/reservation_station.sv
// Reservation station storage: allocation into free slots, CDB wakeup, issue clears, flush, free count
module reservation_station (
    input  logic clock,
    input  logic reset,

    // Dispatch side
    input  logic [issue_pkg::n_way-1:0]                 alloc_valid,
    input  issue_pkg::rs_entry_t [issue_pkg::n_way-1:0] alloc_entries,

    input  issue_pkg::cdb_packet_t                      cdb,  // Wakeup broadcasts

    // Issue side, lane 0 ALU and lane 1 multiply
    input  logic [issue_pkg::n_way-1:0]                 clear_valid,
    input  issue_pkg::rs_idx_t [issue_pkg::n_way-1:0]   clear_idxs,

    input  logic                                        flush,  // Mispredict recovery

    output issue_pkg::rs_entry_t [issue_pkg::rs_size-1:0] entries,
    output issue_pkg::free_count_t                        free_count
);

    issue_pkg::rs_entry_t [issue_pkg::rs_size-1:0] rs_array, rs_array_next;
    logic [issue_pkg::rs_size-1:0]                          free_mask;
    logic [issue_pkg::n_way-1:0][issue_pkg::rs_size-1:0]    alloc_gnt;  // Slot per lane
    issue_pkg::rs_count_t                                   free_cnt, free_cnt_next;

    //////////////////////////////////////////////////
    // Slot choice
    //////////////////////////////////////////////////

    // Empty slots plus slots issuing this cycle
    always_comb begin
        for (int i = 0; i < issue_pkg::rs_size; i++) begin
            free_mask[i] = !rs_array[i].valid;
        end
        for (int l = 0; l < issue_pkg::n_way; l++) begin
            if (clear_valid[l]) free_mask[clear_idxs[l]] = 1'b1;
        end
    end

    slot_select #(
        .width  (issue_pkg::rs_size),
        .grants (issue_pkg::n_way)
    ) i_free_select (
        .req     (free_mask),
        .gnt_bus (alloc_gnt)
    );

    //////////////////////////////////////////////////
    // Next state of the array
    //////////////////////////////////////////////////

    always_comb begin
        rs_array_next = rs_array;

        for (int l = 0; l < issue_pkg::n_way; l++) begin  // Issued entries leave
            if (clear_valid[l]) rs_array_next[clear_idxs[l]].valid = 1'b0;
        end

        for (int l = 0; l < issue_pkg::n_way; l++) begin  // New entries land in granted slots
            for (int i = 0; i < issue_pkg::rs_size; i++) begin
                if (alloc_valid[l] && alloc_gnt[l][i]) rs_array_next[i] = alloc_entries[l];
            end
        end

        // Tag match against every valid slot, new entries included
        for (int i = 0; i < issue_pkg::rs_size; i++) begin
            for (int s = 0; s < issue_pkg::cdb_size; s++) begin
                if (rs_array_next[i].valid && cdb.valid[s]) begin
                    if (!rs_array_next[i].src1_ready && rs_array_next[i].src1_tag == cdb.tags[s]) begin
                        rs_array_next[i].src1_ready = 1'b1;
                        rs_array_next[i].src1_value = cdb.values[s];  // Capture operand
                    end
                    if (!rs_array_next[i].src2_ready && rs_array_next[i].src2_tag == cdb.tags[s]) begin
                        rs_array_next[i].src2_ready = 1'b1;
                        rs_array_next[i].src2_value = cdb.values[s];
                    end
                end
            end
        end
    end

    // Clears give slots back, allocations take them
    assign free_cnt_next = free_cnt
                         + issue_pkg::rs_count_t'($countones(clear_valid))
                         - issue_pkg::rs_count_t'($countones(alloc_valid));

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            free_cnt <= issue_pkg::rs_count_t'(issue_pkg::rs_size);
            rs_array <= '0;  // Every entry invalid
        end else begin
            free_cnt <= free_cnt_next;
            rs_array <= rs_array_next;
        end
    end

    assign entries    = rs_array;
    assign free_count = (free_cnt > issue_pkg::n_way) ? issue_pkg::free_count_t'(issue_pkg::n_way)
                                                      : issue_pkg::free_count_t'(free_cnt);

endmodule

//--- rtl/latency_timer.sv
// Down-counter holding the multiply lane busy for its latency, with a done pulse in the last cycle
module latency_timer (
    input  logic clock,
    input  logic reset,
    input  logic start,   // Load full latency
    input  logic cancel,  // Abort, no done
    output logic busy,
    output logic done
);

    logic [$clog2(issue_pkg::mul_latency+1)-1:0] count;  // Cycles left

    always_ff @(posedge clock) begin
        if (reset || cancel) begin
            count <= '0;
        end else if (start) begin
            count <= ($bits(count))'(issue_pkg::mul_latency);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);
    assign done = (count == 1);  // Final cycle of the run

endmodule

//--- rtl/slot_select.sv
// Priority picker returning the lowest set request bits as one-hot grants, used for free slots and issue
module slot_select #(
    parameter int width  = 8,  // Request vector width
    parameter int grants = 1   // Number of one-hot grants
) (
    input  logic [width-1:0]             req,
    output logic [grants-1:0][width-1:0] gnt_bus
);

    logic [width-1:0] remaining;  // Requests not yet granted

    always_comb begin
        remaining = req;
        for (int k = 0; k < grants; k++) begin
            gnt_bus[k] = remaining & (~remaining + 1'b1);  // Isolate lowest set bit
            remaining  = remaining & ~gnt_bus[k];          // Drop it for the next grant
        end
    end

endmodule

//--- rtl/issue_pkg.sv
// Shared sizes, opcodes and packet structs of the issue cluster, referenced by scoped names
package issue_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int n_way       = 2;   // Dispatch width
    localparam int rs_size     = 8;   // Station entries
    localparam int cdb_size    = 2;   // Slot 0 ALU, slot 1 multiply
    localparam int tag_width   = 6;   // Physical tag bits
    localparam int data_width  = 16;  // Operand bits
    localparam int mul_latency = 3;   // Cycles from issue to broadcast

    typedef logic [$clog2(rs_size)-1:0]   rs_idx_t;      // Entry index
    typedef logic [$clog2(rs_size+1)-1:0] rs_count_t;    // Running free count, 0..rs_size
    typedef logic [$clog2(n_way+1)-1:0]   free_count_t;  // Free count capped at n_way

    typedef logic [tag_width-1:0]  tag_t;
    typedef logic [data_width-1:0] data_t;

    // Opcodes; MUL goes to the multiply lane, the rest to the ALU
    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_xor = 2'd2,
        alu_mul = 2'd3
    } alu_op_t;

    //////////////////////////////////////////////////
    // Packets
    //////////////////////////////////////////////////

    // One station entry; a source is either a value (ready) or waits on its tag
    typedef struct packed {
        logic    valid;
        alu_op_t op;
        tag_t    dest_tag;
        tag_t    src1_tag;
        logic    src1_ready;
        data_t   src1_value;
        tag_t    src2_tag;
        logic    src2_ready;
        data_t   src2_value;
    } rs_entry_t;

    // Common data bus, one slot per lane
    typedef struct packed {
        logic [cdb_size-1:0]        valid;
        tag_t [cdb_size-1:0]        tags;
        data_t [cdb_size-1:0]       values;
    } cdb_packet_t;

    // Operation handed from issue to a lane
    typedef struct packed {
        logic    valid;
        alu_op_t op;
        tag_t    dest_tag;
        data_t   src1_value;
        data_t   src2_value;
    } issue_packet_t;

endpackage
